// File: cpuPkg.sv
package cpuPkg;

    // Datapath and address width
    localparam int XLEN = 32;

    // Memory depths in words
    localparam int IMEM_WORDS = 256;
    localparam int DMEM_WORDS = 256;

    // Word index widths
    localparam int IMEM_AW = $clog2(IMEM_WORDS);
    localparam int DMEM_AW = $clog2(DMEM_WORDS);

    // funct3 codes for the R-type and I-type ALU group
    localparam logic [2:0] F3_ADDSUB = 3'b000;
    localparam logic [2:0] F3_SLT    = 3'b010;
    localparam logic [2:0] F3_XOR    = 3'b100;
    localparam logic [2:0] F3_OR     = 3'b110;
    localparam logic [2:0] F3_AND    = 3'b111;

    typedef logic [XLEN-1:0] wordT;
    typedef logic [4:0]      regAddrT;

    // Major opcodes in the supported subset
    typedef enum logic [6:0] {
        OP_R      = 7'b0110011,  // add sub and or xor slt
        OP_IMM    = 7'b0010011,  // addi
        OP_LOAD   = 7'b0000011,  // lw
        OP_STORE  = 7'b0100011,  // sw
        OP_BRANCH = 7'b1100011   // beq
    } opcodeE;

    // ALU operations
    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLT = 3'd5
    } aluOpE;

endpackage

// File: cpuCtrlIf.sv
`timescale 1ns/1ps

// Decoded control bundle, decoder to datapath
interface cpuCtrlIf;
    import cpuPkg::*;

    logic  regWrite;
    logic  aluSrc;    // High selects imm as ALU operand b
    logic  memWrite;
    logic  memToReg;  // Writeback from data memory
    logic  branch;
    aluOpE aluOp;
    wordT  imm;

    modport dec (
        output regWrite, aluSrc, memWrite, memToReg, branch, aluOp, imm
    );

    modport dp (
        input regWrite, aluSrc, memWrite, memToReg, branch, aluOp, imm
    );

endinterface

// File: instMem.sv
`timescale 1ns/1ps

module instMem (
    input  logic                       CLK,
    input  cpuPkg::wordT               addr,      // Byte address
    output cpuPkg::wordT               inst,
    input  logic                       loadWe,
    input  logic [cpuPkg::IMEM_AW-1:0] loadAddr,  // Word index
    input  cpuPkg::wordT               loadData
);
    import cpuPkg::*;

    wordT               mem [IMEM_WORDS];
    logic [IMEM_AW-1:0] wordIdx;
    logic               inRange;

    // Start from an all-zero image
    initial begin
        for (int i = 0; i < IMEM_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    // Program load port
    always_ff @(posedge CLK) begin
        if (loadWe) begin
            mem[loadAddr] <= loadData;
        end
    end

    assign wordIdx = addr[IMEM_AW+1:2];
    assign inRange = (addr[XLEN-1:IMEM_AW+2] == '0);

    // Beyond the array reads as zero
    assign inst = inRange ? mem[wordIdx] : '0;

    // Fetch must stay on word boundaries
    assert property (@(posedge CLK)
        !$isunknown(addr) |-> addr[1:0] == 2'b00)
        else $error("instMem: misaligned fetch address %h", addr);

endmodule

// File: regFile.sv
`timescale 1ns/1ps

module regFile (
    input  logic            CLK,
    input  logic            RST,
    input  cpuPkg::regAddrT rs1,
    input  cpuPkg::regAddrT rs2,
    input  cpuPkg::regAddrT rd,
    input  logic            we,
    input  cpuPkg::wordT    wd,
    output cpuPkg::wordT    rd1,
    output cpuPkg::wordT    rd2
);
    import cpuPkg::*;

    // x0 has an entry that is never written
    wordT regs [32];

    always_ff @(posedge CLK) begin
        if (RST) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != '0) begin
            regs[rd] <= wd;
        end
    end

    // Reads see the value before this edge's write
    assign rd1 = regs[rs1];
    assign rd2 = regs[rs2];

    // x0 stays zero even after a write aimed at it
    assert property (@(posedge CLK) disable iff (RST)
        (rs1 != '0 || rd1 == '0) && (rs2 != '0 || rd2 == '0))
        else $error("regFile: x0 read back nonzero");

endmodule

// File: decoder.sv
`timescale 1ns/1ps

module decoder (
    input  cpuPkg::wordT inst,
    cpuCtrlIf.dec        ctrl
);
    import cpuPkg::*;

    opcodeE     opcode;
    logic [2:0] funct3;
    logic       funct7b5;
    wordT       immI;
    wordT       immS;
    wordT       immB;

    assign opcode   = opcodeE'(inst[6:0]);
    assign funct3   = inst[14:12];
    assign funct7b5 = inst[30];

    // Sign-extended immediates
    assign immI = {{20{inst[31]}}, inst[31:20]};
    assign immS = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign immB = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};  // Pre-shifted

    // ALU group decode shared by R-type and addi
    function automatic aluOpE aluFromFunct(input logic [2:0] f3, input logic subSel);
        aluOpE op;
        case (f3)
            F3_ADDSUB: op = subSel ? ALU_SUB : ALU_ADD;
            F3_SLT:    op = ALU_SLT;
            F3_XOR:    op = ALU_XOR;
            F3_OR:     op = ALU_OR;
            F3_AND:    op = ALU_AND;
            default:   op = ALU_ADD;
        endcase
        return op;
    endfunction

    always_comb begin
        ctrl.regWrite = 1'b0;
        ctrl.aluSrc   = 1'b0;
        ctrl.memWrite = 1'b0;
        ctrl.memToReg = 1'b0;
        ctrl.branch   = 1'b0;
        ctrl.aluOp    = ALU_ADD;
        ctrl.imm      = '0;
        case (opcode)
            OP_R: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluOp    = aluFromFunct(funct3, funct7b5);
            end
            OP_IMM: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.aluOp    = aluFromFunct(funct3, 1'b0);  // No subi in RV32I
                ctrl.imm      = immI;
            end
            OP_LOAD: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.memToReg = 1'b1;
                ctrl.imm      = immI;
            end
            OP_STORE: begin
                ctrl.aluSrc   = 1'b1;
                ctrl.memWrite = 1'b1;
                ctrl.imm      = immS;
            end
            OP_BRANCH: begin
                ctrl.branch   = 1'b1;
                ctrl.aluOp    = ALU_SUB;  // Equal when difference is zero
                ctrl.imm      = immB;
            end
            default: ;  // Unknown opcode acts as a no-op
        endcase
    end

endmodule

// File: alu.sv
`timescale 1ns/1ps

module alu (
    input  cpuPkg::wordT  a,
    input  cpuPkg::wordT  b,
    input  cpuPkg::aluOpE op,
    output cpuPkg::wordT  y,
    output logic          zero
);
    import cpuPkg::*;

    logic lessThan;

    // Signed compare for slt
    assign lessThan = $signed(a) < $signed(b);

    always_comb begin
        case (op)
            ALU_ADD: y = a + b;
            ALU_SUB: y = a - b;
            ALU_AND: y = a & b;
            ALU_OR:  y = a | b;
            ALU_XOR: y = a ^ b;
            ALU_SLT: y = {{(XLEN-1){1'b0}}, lessThan};
            default: y = '0;
        endcase
    end

    assign zero = (y == '0);  // Drives beq

    // Only encoded operations may reach the ALU
    always_comb begin
        assert ($isunknown(op) || op inside {ALU_ADD, ALU_SUB, ALU_AND,
                                             ALU_OR, ALU_XOR, ALU_SLT})
            else $error("alu: illegal operation code %0d", op);
    end

endmodule

// File: dataMem.sv
`timescale 1ns/1ps

module dataMem (
    input  logic         CLK,
    input  cpuPkg::wordT addr,  // Byte address
    input  logic         we,
    input  cpuPkg::wordT wd,
    output cpuPkg::wordT rd
);
    import cpuPkg::*;

    wordT               mem [DMEM_WORDS];
    logic [DMEM_AW-1:0] wordIdx;

    // Cleared at start so unwritten words load as zero
    initial begin
        for (int i = 0; i < DMEM_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    assign wordIdx = addr[DMEM_AW+1:2];

    always_ff @(posedge CLK) begin
        if (we) begin
            mem[wordIdx] <= wd;
        end
    end

    assign rd = mem[wordIdx];  // Same-cycle read

    assert property (@(posedge CLK) we |-> addr[1:0] == 2'b00)
        else $error("dataMem: misaligned store to %h", addr);

endmodule

// File: singleCpu.sv
`timescale 1ns/1ps

module singleCpu (
    input  logic                       CLK,
    input  logic                       RST,
    input  logic                       progWe,
    input  logic [cpuPkg::IMEM_AW-1:0] progAddr,
    input  cpuPkg::wordT               progData,
    output cpuPkg::wordT               pc,
    output cpuPkg::wordT               inst,
    output logic                       wbValid,
    output cpuPkg::regAddrT            wbAddr,
    output cpuPkg::wordT               wbData
);
    import cpuPkg::*;

    cpuCtrlIf ctrlIf ();

    wordT    rs1Data;
    wordT    rs2Data;
    wordT    aluB;
    wordT    aluY;
    logic    aluZero;
    wordT    memRd;
    logic    memWe;
    wordT    wbValue;
    regAddrT rdAddr;
    wordT    pcPlus4;
    wordT    branchTarget;
    logic    takeBranch;
    wordT    pcNext;

    instMem instMem_i (
        .CLK      (CLK),
        .addr     (pc),
        .inst     (inst),
        .loadWe   (progWe),
        .loadAddr (progAddr),
        .loadData (progData)
    );

    decoder decoder_i (
        .inst (inst),
        .ctrl (ctrlIf.dec)
    );

    assign rdAddr = inst[11:7];

    regFile regFile_i (
        .CLK (CLK),
        .RST (RST),
        .rs1 (inst[19:15]),
        .rs2 (inst[24:20]),
        .rd  (rdAddr),
        .we  (ctrlIf.regWrite),
        .wd  (wbValue),
        .rd1 (rs1Data),
        .rd2 (rs2Data)
    );

    assign aluB = ctrlIf.aluSrc ? ctrlIf.imm : rs2Data;

    alu alu_i (
        .a    (rs1Data),
        .b    (aluB),
        .op   (ctrlIf.aluOp),
        .y    (aluY),
        .zero (aluZero)
    );

    // No stores while the program is still loading
    assign memWe = ctrlIf.memWrite && !RST;

    dataMem dataMem_i (
        .CLK  (CLK),
        .addr (aluY),
        .we   (memWe),
        .wd   (rs2Data),
        .rd   (memRd)
    );

    assign wbValue = ctrlIf.memToReg ? memRd : aluY;

    // Next PC
    assign pcPlus4      = pc + 32'd4;
    assign branchTarget = pc + ctrlIf.imm;
    assign takeBranch   = ctrlIf.branch && aluZero;
    assign pcNext       = takeBranch ? branchTarget : pcPlus4;

    always_ff @(posedge CLK) begin
        if (RST) begin
            pc <= '0;
        end else begin
            pc <= pcNext;
        end
    end

    // Observation of the register write at the coming edge
    assign wbValid = ctrlIf.regWrite && (rdAddr != '0) && !RST;
    assign wbAddr  = rdAddr;
    assign wbData  = wbValue;

    // Only subset opcodes expected once the program runs
    assert property (@(posedge CLK) disable iff (RST)
        inst[6:0] inside {OP_R, OP_IMM, OP_LOAD, OP_STORE, OP_BRANCH})
        else $error("singleCpu: unknown opcode %b at pc %h", inst[6:0], pc);

endmodule

// File: tbSingleCpu.sv
`timescale 1ns/1ps

module tbSingleCpu;
    import cpuPkg::*;

    localparam int    RESET_CYCLES = 16;
    localparam int    QUIET_CYCLES = 12;  // Idle cycles watched in the final loop
    localparam string TEST_FILE    = "cpuTests.txt";

    // One expected register write
    typedef struct packed {
        regAddrT rd;
        wordT    value;
    } wbRecordT;

    logic               CLK = 1'b1;
    logic               RST;
    logic               progWe;
    logic [IMEM_AW-1:0] progAddr;
    wordT               progData;
    wordT               pc;
    wordT               inst;
    logic               wbValid;
    regAddrT            wbAddr;
    wordT               wbData;

    int       progIdx[$];
    wordT     progWords[$];
    wbRecordT expected[$];
    wordT     progImage [IMEM_WORDS];  // Loaded program, zero elsewhere
    wordT     shadowRegs [32];         // Register values implied by the records
    wordT     expPc;
    int       watchdogCycles;

    singleCpu singleCpu_i (
        .CLK      (CLK),
        .RST      (RST),
        .progWe   (progWe),
        .progAddr (progAddr),
        .progData (progData),
        .pc       (pc),
        .inst     (inst),
        .wbValid  (wbValid),
        .wbAddr   (wbAddr),
        .wbData   (wbData)
    );

    always #2 CLK = ~CLK;  // 4 ns period

    task automatic stopWithFailure(input string reason);
        $display("%s", reason);
        $display("Verification failed");
        $fatal(1, "Run stopped at %0t", $time);
    endtask

    task automatic compareReg(input string name, input regAddrT got, input regAddrT exp);
        if (got !== exp) begin
            stopWithFailure($sformatf("FAILED at %0t: %s = x%0d, expected x%0d",
                                      $time, name, got, exp));
        end
    endtask

    task automatic compareWord(input string name, input wordT got, input wordT exp);
        if (got !== exp) begin
            stopWithFailure($sformatf("FAILED at %0t: %s = %h, expected %h",
                                      $time, name, got, exp));
        end
    endtask

    // P lines go to the program queues, W lines to the expected records
    task automatic readTests();
        int       fd;
        int       code;
        int       idx;
        int       lineNo;
        string    line;
        string    tag;
        wordT     word;
        wbRecordT rec;
        fd = $fopen(TEST_FILE, "r");
        if (fd == 0) begin
            stopWithFailure({"Cannot open the test file ", TEST_FILE});
        end else begin
            lineNo = 0;
            while ($fgets(line, fd) > 0) begin
                lineNo++;
                tag  = "";
                code = $sscanf(line, "%s %d %h", tag, idx, word);
                if (code >= 1 && tag != "#") begin
                    if (code == 3 && tag == "P") begin
                        progIdx.push_back(idx);
                        progWords.push_back(word);
                    end else if (code == 3 && tag == "W") begin
                        rec.rd    = regAddrT'(idx);
                        rec.value = word;
                        expected.push_back(rec);
                    end else begin
                        stopWithFailure($sformatf("Line %0d of the test file is malformed",
                                                  lineNo));
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // One program word per falling edge while RST is high
    task automatic loadProgram();
        for (int i = 0; i < RESET_CYCLES; i++) begin
            @(negedge CLK);
            if (i < progWords.size()) begin
                progWe   = 1'b1;
                progAddr = IMEM_AW'(progIdx[i]);
                progData = progWords[i];
                progImage[progAddr] = progWords[i];
            end else begin
                progWe   = 1'b0;
            end
        end
    endtask

    // Word at the byte address divided by four, zero beyond the array
    function automatic wordT expectedInst(input wordT addr);
        wordT idx;
        idx = addr / 4;
        if (idx < IMEM_WORDS) begin
            return progImage[IMEM_AW'(idx)];
        end
        return '0;
    endfunction

    // PC plus 4, or PC plus the B offset for a beq with equal operands
    function automatic wordT nextPc(input wordT addr);
        wordT word;
        wordT offset;
        word   = expectedInst(addr);
        offset = {{19{word[31]}}, word[31], word[7], word[30:25], word[11:8], 1'b0};
        if (opcodeE'(word[6:0]) == OP_BRANCH
            && shadowRegs[word[19:15]] == shadowRegs[word[24:20]]) begin
            return addr + offset;
        end
        return addr + 32'd4;
    endfunction

    task automatic checkWriteback();
        wbRecordT rec;
        opcodeE   op;
        if (expected.size() == 0) begin
            op = opcodeE'(inst[6:0]);
            stopWithFailure($sformatf(
                "Unexpected writeback of %h to x%0d by %s at pc %h, no record was left",
                wbData, wbAddr, op.name(), pc));
        end else begin
            rec = expected.pop_front();
            compareReg("wbAddr", wbAddr, rec.rd);
            compareWord("wbData", wbData, rec.value);
            shadowRegs[rec.rd] = rec.value;
        end
    endtask

    // Fetch and writeback of one cycle, then the model moves to the next PC
    task automatic inspectCycle();
        compareWord("pc", pc, expPc);
        compareWord("inst", inst, expectedInst(expPc));
        if (wbValid) begin
            checkWriteback();
        end
        expPc = nextPc(expPc);
    endtask

    initial begin
        RST            = 1'b1;
        progWe         = 1'b0;
        progAddr       = '0;
        progData       = '0;
        expPc          = '0;
        watchdogCycles = 0;
        foreach (progImage[i]) begin
            progImage[i] = '0;
        end
        foreach (shadowRegs[i]) begin
            shadowRegs[i] = '0;
        end
        readTests();
        if (progWords.size() == 0 || progWords.size() > RESET_CYCLES) begin
            stopWithFailure($sformatf("Program of %0d words does not fit the reset window",
                                      progWords.size()));
        end else if (expected.size() == 0) begin
            stopWithFailure("The test file holds no expected writebacks");
        end else begin
            watchdogCycles = RESET_CYCLES + 2 * progWords.size() + 50;
            loadProgram();
            @(negedge CLK);
            RST    = 1'b0;
            progWe = 1'b0;
            // Writes land at the rising edge, so sample there
            while (expected.size() > 0) begin
                @(posedge CLK);
                inspectCycle();
            end
            // beq x0,x0,0 loop must stay silent
            repeat (QUIET_CYCLES) begin
                @(posedge CLK);
                inspectCycle();
            end
            $display("Verification passed");
            $finish;
        end
    end

    // Watchdog
    initial begin
        wait (watchdogCycles > 0);
        repeat (watchdogCycles) @(posedge CLK);
        stopWithFailure($sformatf(
            "Timeout after %0d cycles, %0d expected writebacks never arrived",
            watchdogCycles, expected.size()));
    end

endmodule

// File: cpuTests.txt
# P <word index> <instruction hex>   program word loaded during reset
# W <register> <value hex>           expected writeback, in retirement order
P 0  06400093   # addi x1, x0, 100
P 1  f9508113   # addi x2, x1, -107  reads x1 right after its write
P 2  00508013   # addi x0, x1, 5     no record
P 3  002081b3   # add  x3, x1, x2
P 4  40110233   # sub  x4, x2, x1
P 5  0020f2b3   # and  x5, x1, x2
P 6  00116333   # or   x6, x2, x1
P 7  004143b3   # xor  x7, x2, x4
P 8  00208463   # beq  x1, x2, 8     not taken
P 9  00122433   # slt  x8, x4, x1    negative against positive
P 10 00402423   # sw   x4, 8(x0)
P 11 00802483   # lw   x9, 8(x0)
P 12 00c02503   # lw   x10, 12(x0)   never written
P 13 00318463   # beq  x3, x3, 8     taken
P 14 00100593   # addi x11, x0, 1    skipped
P 15 00000063   # beq  x0, x0, 0     final loop
W 1  00000064   # 100
W 2  fffffff9   # -7
W 3  0000005d   # 93
W 4  ffffff95   # -107
W 5  00000060   # 100 and -7
W 6  fffffffd   # -7 or 100
W 7  0000006c   # -7 xor -107
W 8  00000001   # -107 < 100
W 9  ffffff95   # stored word
W 10 00000000   # cleared memory

// File: compile.f
cpuPkg.sv
cpuCtrlIf.sv
instMem.sv
regFile.sv
decoder.sv
alu.sv
dataMem.sv
singleCpu.sv
tbSingleCpu.sv

// File: Makefile
VERILATOR ?= verilator
SIMFLAGS  := --binary --timing --assert -j 0
LINTFLAGS := --lint-only --timing --assert
TOP       := tbSingleCpu
FILELIST  := compile.f
OBJDIR    := obj_dir
PASSTEXT  := Verification passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(SIMFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASSTEXT)"

clean:
	rm -rf $(OBJDIR)
